// ==== source/soc_pkg.sv ====
// package with the address map, bus widths, request opcode and request/response structs
`default_nettype none

package soc_pkg;

  // bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned STRB_W     = DATA_W / 8;

  // host ids are squeezed into a small slot index
  localparam int unsigned HOST_ID_W  = 8;
  localparam int unsigned TABLE_SIZE = 4;
  localparam int unsigned BUS_ID_W   = $clog2(TABLE_SIZE);

  // l2 address map
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h1C00_0000;
  localparam int unsigned L2_SIZE    = 4096;
  localparam int unsigned L2_N_BANKS = 2;
  localparam int unsigned BANK_BYTES = L2_SIZE / L2_N_BANKS;
  localparam int unsigned BANK_WORDS = BANK_BYTES / STRB_W;

  // derived offsets inside the l2 window
  localparam int unsigned WORD_OFF_W = $clog2(STRB_W);
  localparam int unsigned BANK_IDX_W = $clog2(BANK_WORDS);
  localparam int unsigned BANK_OFF_W = $clog2(BANK_BYTES);
  localparam int unsigned BANK_SEL_W = $clog2(L2_N_BANKS);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_e;

  // host side, wide id
  typedef struct packed {
    req_op_e               op;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     strb;
    logic [HOST_ID_W-1:0]  id;
  } host_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]     rdata;
    logic                  err;
    logic [HOST_ID_W-1:0]  id;
  } host_rsp_t;

  // soc bus side, id is the remap slot
  typedef struct packed {
    req_op_e               op;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     strb;
    logic [BUS_ID_W-1:0]   id;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]     rdata;
    logic                  err;
    logic [BUS_ID_W-1:0]   id;
  } bus_rsp_t;

  // request as seen by one bank, address already reduced to a word index
  typedef struct packed {
    req_op_e               op;
    logic [BANK_IDX_W-1:0] idx;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     strb;
    logic [BUS_ID_W-1:0]   id;
  } bank_req_t;

endpackage

`default_nettype wire

// ==== source/id_remap.sv ====
// id remapper: slot table for host ids and the registered request towards the soc bus
`timescale 1ns/1ps
`default_nettype none

module id_remap (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               host_req_valid_i,
  input  soc_pkg::host_req_t host_req_i,
  output logic               host_req_ready_o,
  output logic               host_rsp_valid_o,
  output soc_pkg::host_rsp_t host_rsp_o,
  output logic               bus_req_valid_o,
  output soc_pkg::bus_req_t  bus_req_o,
  input  logic               bus_rsp_valid_i,
  input  soc_pkg::bus_rsp_t  bus_rsp_i
);

  import soc_pkg::*;

  logic [TABLE_SIZE-1:0] used_q;
  logic [TABLE_SIZE-1:0] used_d;
  logic [TABLE_SIZE-1:0] free_mask;
  logic [TABLE_SIZE-1:0] avail;
  logic [BUS_ID_W-1:0]   alloc_idx;
  logic                  accept;
  logic [HOST_ID_W-1:0]  id_table_q [TABLE_SIZE];
  logic                  bus_req_valid_q;
  bus_req_t              bus_req_q;

  // slot handed back by this cycle's response
  always_comb begin
    free_mask = '0;
    if (bus_rsp_valid_i) begin
      free_mask[bus_rsp_i.id] = 1'b1;
    end
  end

  // a slot freed this cycle may be reused right away
  assign avail = ~used_q | free_mask;

  // lowest available slot wins
  always_comb begin
    alloc_idx = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (avail[i]) begin
        alloc_idx = BUS_ID_W'(i);
      end
    end
  end

  assign host_req_ready_o = |avail;
  assign accept           = host_req_valid_i & host_req_ready_o;

  always_comb begin
    used_d = used_q & ~free_mask;
    if (accept) begin
      used_d[alloc_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      used_q          <= '0;
      bus_req_valid_q <= 1'b0;
    end else begin
      used_q          <= used_d;
      bus_req_valid_q <= accept;
    end
  end

  // host id kept per slot, request forwarded with the slot as id
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_table_q[alloc_idx] <= host_req_i.id;
      bus_req_q.op          <= host_req_i.op;
      bus_req_q.addr        <= host_req_i.addr;
      bus_req_q.wdata       <= host_req_i.wdata;
      bus_req_q.strb        <= host_req_i.strb;
      bus_req_q.id          <= alloc_idx;
    end
  end

  assign bus_req_valid_o = bus_req_valid_q;
  assign bus_req_o       = bus_req_q;

  // response path is pure lookup, no extra cycle
  assign host_rsp_valid_o = bus_rsp_valid_i;
  assign host_rsp_o.rdata = bus_rsp_i.rdata;
  assign host_rsp_o.err   = bus_rsp_i.err;
  assign host_rsp_o.id    = id_table_q[bus_rsp_i.id];

  // downstream only ever answers on slots this table handed out
  a_rsp_slot_used: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_rsp_valid_i |-> used_q[bus_rsp_i.id])
    else $error("response on free slot %0d", bus_rsp_i.id);

endmodule

`default_nettype wire

// ==== source/soc_bus.sv ====
// soc bus: l2 address decode, bank steering, error responder and response merge
`timescale 1ns/1ps
`default_nettype none

module soc_bus (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        req_valid_i,
  input  soc_pkg::bus_req_t                           req_i,
  output logic                                        rsp_valid_o,
  output soc_pkg::bus_rsp_t                           rsp_o,
  output logic [soc_pkg::L2_N_BANKS-1:0]              bank_req_valid_o,
  output soc_pkg::bank_req_t                          bank_req_o,
  input  logic [soc_pkg::L2_N_BANKS-1:0]              bank_rsp_valid_i,
  input  soc_pkg::bus_rsp_t [soc_pkg::L2_N_BANKS-1:0] bank_rsp_i
);

  import soc_pkg::*;

  logic [ADDR_W-1:0]     l2_off;
  logic                  in_l2;
  logic [BANK_SEL_W-1:0] bank_sel;
  logic                  err_valid_q;
  logic [BUS_ID_W-1:0]   err_id_q;

  // below the base wraps around to a large offset, so one compare covers both ends
  assign l2_off   = req_i.addr - L2_BASE;
  assign in_l2    = l2_off < ADDR_W'(L2_SIZE);
  assign bank_sel = l2_off[BANK_OFF_W +: BANK_SEL_W];

  always_comb begin
    for (int b = 0; b < L2_N_BANKS; b++) begin
      bank_req_valid_o[b] = req_valid_i & in_l2 & (bank_sel == BANK_SEL_W'(b));
    end
  end

  // shared request, only the selected bank sees a valid
  assign bank_req_o.op    = req_i.op;
  assign bank_req_o.idx   = l2_off[WORD_OFF_W +: BANK_IDX_W];
  assign bank_req_o.wdata = req_i.wdata;
  assign bank_req_o.strb  = req_i.strb;
  assign bank_req_o.id    = req_i.id;

  // decode miss, answered one cycle later like a bank would
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= req_valid_i & ~in_l2;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      err_id_q <= req_i.id;
    end
  end

  // equal latency on all paths keeps these mutually exclusive
  always_comb begin
    rsp_valid_o = err_valid_q;
    rsp_o.rdata = '0;
    rsp_o.err   = err_valid_q;
    rsp_o.id    = err_id_q;
    for (int b = 0; b < L2_N_BANKS; b++) begin
      if (bank_rsp_valid_i[b]) begin
        rsp_valid_o = 1'b1;
        rsp_o       = bank_rsp_i[b];
      end
    end
  end

  a_bank_rsp_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(bank_rsp_valid_i))
    else $error("more than one bank response in a cycle");

  a_err_vs_bank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    err_valid_q |-> bank_rsp_valid_i == '0)
    else $error("error response collides with a bank response");

endmodule

`default_nettype wire

// ==== source/l2_bank.sv ====
// one l2 bank: byte-strobed word memory with a registered response
`timescale 1ns/1ps
`default_nettype none

module l2_bank (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_valid_i,
  input  soc_pkg::bank_req_t  req_i,
  output logic                rsp_valid_o,
  output soc_pkg::bus_rsp_t   rsp_o
);

  import soc_pkg::*;

  logic [DATA_W-1:0]   mem_q [BANK_WORDS];
  logic                wr_en;
  logic                rsp_valid_q;
  logic [DATA_W-1:0]   rdata_q;
  logic [BUS_ID_W-1:0] rsp_id_q;

  assign wr_en = req_valid_i & (req_i.op == OP_WRITE);

  // byte lanes written only where strobed
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (req_i.strb[i]) begin
          mem_q[req_i.idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_id_q <= req_i.id;
      rdata_q  <= wr_en ? '0 : mem_q[req_i.idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.id    = rsp_id_q;

endmodule

`default_nettype wire

// ==== source/soc_top.sv ====
// top level: host id remapper, soc bus and the l2 banks
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               host_req_valid_i,
  input  soc_pkg::host_req_t host_req_i,
  output logic               host_req_ready_o,
  output logic               host_rsp_valid_o,
  output soc_pkg::host_rsp_t host_rsp_o
);

  import soc_pkg::*;

  // remapper to bus
  logic     bus_req_valid;
  bus_req_t bus_req;
  logic     bus_rsp_valid;
  bus_rsp_t bus_rsp;

  // bus to banks
  logic [L2_N_BANKS-1:0]     bank_req_valid;
  bank_req_t                 bank_req;
  logic [L2_N_BANKS-1:0]     bank_rsp_valid;
  bus_rsp_t [L2_N_BANKS-1:0] bank_rsp;

  id_remap i_id_remap (
    .clk_i,
    .arst_n_i,
    .host_req_valid_i,
    .host_req_i,
    .host_req_ready_o,
    .host_rsp_valid_o,
    .host_rsp_o,
    .bus_req_valid_o  (bus_req_valid),
    .bus_req_o        (bus_req),
    .bus_rsp_valid_i  (bus_rsp_valid),
    .bus_rsp_i        (bus_rsp)
  );

  soc_bus i_soc_bus (
    .clk_i,
    .arst_n_i,
    .req_valid_i      (bus_req_valid),
    .req_i            (bus_req),
    .rsp_valid_o      (bus_rsp_valid),
    .rsp_o            (bus_rsp),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_o       (bank_req),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_i       (bank_rsp)
  );

  for (genvar b = 0; b < L2_N_BANKS; b++) begin : gen_banks
    l2_bank i_l2_bank (
      .clk_i,
      .arst_n_i,
      .req_valid_i (bank_req_valid[b]),
      .req_i       (bank_req),
      .rsp_valid_o (bank_rsp_valid[b]),
      .rsp_o       (bank_rsp[b])
    );
  end

endmodule

`default_nettype wire

// ==== tests/tb_soc_top.sv ====
// testbench for soc_top: clock, reset, stimulus, reference memory model and response checks
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

  import soc_pkg::*;

  logic                 clk;
  logic                 arst_n;
  logic                 req_valid;
  host_req_t            req;
  logic                 req_ready;
  logic                 rsp_valid;
  host_rsp_t            rsp;
  logic                 accepted;

  integer               seed;
  logic [DATA_W-1:0]    model [logic [ADDR_W-1:0]];
  host_rsp_t            exp_q [$];
  host_rsp_t            exp_head;
  int                   pending;
  logic [ADDR_W-1:0]    burst_addr [6];
  logic [HOST_ID_W-1:0] id_base;
  logic [ADDR_W-1:0]    known_addr;
  logic [ADDR_W-1:0]    ofs_addr;

  always #4 clk = ~clk;

  soc_top UUT (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .host_req_valid_i (req_valid),
    .host_req_i       (req),
    .host_req_ready_o (req_ready),
    .host_rsp_valid_o (rsp_valid),
    .host_rsp_o       (rsp)
  );

  assign accepted = req_valid & req_ready;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  // expected response of a request and the model update for writes
  function automatic host_rsp_t apply_to_model(input host_req_t r);
    host_rsp_t         e;
    logic [ADDR_W-1:0] key;
    logic [DATA_W-1:0] word;
    e.id    = r.id;
    e.err   = 1'b0;
    e.rdata = '0;
    key     = r.addr & ~ADDR_W'(STRB_W - 1);
    if (r.addr < L2_BASE || r.addr >= L2_BASE + ADDR_W'(L2_SIZE)) begin
      e.err = 1'b1;
    end else if (r.op == OP_WRITE) begin
      word = model.exists(key) ? model[key] : '0;
      for (int i = 0; i < STRB_W; i++) begin
        if (r.strb[i]) begin
          word[8*i +: 8] = r.wdata[8*i +: 8];
        end
      end
      model[key] = word;
    end else begin
      e.rdata = model.exists(key) ? model[key] : '0;
    end
    return e;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_l2_addr();
    logic [31:0] r;
    r = $random(seed);
    return L2_BASE + (r & ADDR_W'(L2_SIZE - STRB_W));
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [HOST_ID_W-1:0] rand_id();
    logic [31:0] r;
    r = $random(seed);
    return r[HOST_ID_W-1:0];
  endfunction

  // expected queue, head and count are published with NBAs for the assertions
  always @(posedge clk) begin
    if (arst_n) begin
      if (rsp_valid && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (accepted) begin
        exp_q.push_back(apply_to_model(req));
      end
    end
    exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
    pending  <= exp_q.size();
  end

  a_rsp_latency: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid == $past(accepted, 2))
    else stop_run($sformatf("FAIL @%0t: response valid %0b, expected %0b",
                            $time, rsp_valid, !rsp_valid));

  a_rsp_value: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |-> (pending != 0 && rsp == exp_head))
    else stop_run($sformatf("FAIL @%0t: rsp id %02h err %0b rdata %016h exp %02h %0b %016h",
                            $time, rsp.id, rsp.err, rsp.rdata,
                            exp_head.id, exp_head.err, exp_head.rdata));

  // call right after a rising edge, returns on the accepting edge
  task automatic send_request(input req_op_e op, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                              input logic [HOST_ID_W-1:0] id);
    host_req_t r;
    int        waited;
    r.op      = op;
    r.addr    = addr;
    r.wdata   = wdata;
    r.strb    = strb;
    r.id      = id;
    req_valid <= 1'b1;
    req       <= r;
    waited    = 0;
    @(posedge clk);
    while (!req_ready) begin
      waited++;
      if (waited == 100) begin
        stop_run("timed out waiting for the host port to become ready");
      end
      @(posedge clk);
    end
  endtask

  // drop valid and let every outstanding response come back
  task automatic end_burst();
    int waited;
    req_valid <= 1'b0;
    waited    = 0;
    @(posedge clk);
    while (pending != 0) begin
      waited++;
      if (waited == 100) begin
        stop_run("timed out waiting for outstanding responses to return");
      end
      @(posedge clk);
    end
  endtask

  initial begin
    seed      = 32'h7bd8_b744;
    clk       = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    a_idle_after_reset: assert (req_ready && !rsp_valid)
      else stop_run($sformatf("FAIL @%0t: after reset ready %0b rsp valid %0b",
                              $time, req_ready, rsp_valid));

    // full word write, then read back
    known_addr = rand_l2_addr();
    send_request(OP_WRITE, known_addr, rand_word(), '1, rand_id());
    send_request(OP_READ, known_addr, '0, '0, rand_id());
    end_burst();

    // partial strobes over the known word
    send_request(OP_WRITE, known_addr, rand_word(), 8'h5a, rand_id());
    send_request(OP_READ, known_addr, '0, '0, rand_id());
    send_request(OP_WRITE, known_addr, rand_word(), 8'h81, rand_id());
    send_request(OP_READ, known_addr, '0, '0, rand_id());
    end_burst();

    // same offset in both banks
    ofs_addr = L2_BASE + (rand_l2_addr() & ADDR_W'(BANK_BYTES - STRB_W));
    send_request(OP_WRITE, ofs_addr, rand_word(), '1, rand_id());
    send_request(OP_WRITE, ofs_addr + ADDR_W'(BANK_BYTES), rand_word(), '1, rand_id());
    send_request(OP_READ, ofs_addr, '0, '0, rand_id());
    send_request(OP_READ, ofs_addr + ADDR_W'(BANK_BYTES), '0, '0, rand_id());
    end_burst();

    // just above, just below and far outside l2
    send_request(OP_WRITE, known_addr + ADDR_W'(L2_SIZE), rand_word(), '1, rand_id());
    send_request(OP_READ, L2_BASE - ADDR_W'(STRB_W), '0, '0, rand_id());
    send_request(OP_WRITE, 32'h0000_0000, rand_word(), '1, rand_id());
    send_request(OP_READ, known_addr, '0, '0, rand_id());
    end_burst();

    // back-to-back burst with distinct ids
    id_base = rand_id();
    for (int i = 0; i < 6; i++) begin
      burst_addr[i] = rand_l2_addr();
      send_request(OP_WRITE, burst_addr[i], rand_word(), '1, id_base + HOST_ID_W'(i * 37));
    end
    for (int i = 0; i < 6; i++) begin
      send_request(OP_READ, burst_addr[i], '0, '0, id_base + HOST_ID_W'(i * 37 + 18));
    end
    end_burst();

    if (exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      stop_run("responses were still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/soc_pkg.sv
source/id_remap.sv
source/soc_bus.sv
source/l2_bank.sv
source/soc_top.sv
tests/tb_soc_top.sv

// ==== Makefile ====
TOP = tb_soc_top

all: run

build:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
